// File: hw/rv_pkg.sv
`default_nettype none

package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_num_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [3:0]  alu_op_t;

    // Major opcodes
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_LUI    = 7'b0110111;

    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // SUB and SRA

    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_SLL  = 4'd2;
    localparam alu_op_t ALU_SLT  = 4'd3;
    localparam alu_op_t ALU_SLTU = 4'd4;
    localparam alu_op_t ALU_XOR  = 4'd5;
    localparam alu_op_t ALU_SRL  = 4'd6;
    localparam alu_op_t ALU_SRA  = 4'd7;
    localparam alu_op_t ALU_OR   = 4'd8;
    localparam alu_op_t ALU_AND  = 4'd9;
    localparam alu_op_t ALU_LUI  = 4'd10; // Immediate passes through

endpackage

`default_nettype wire

// File: hw/rv_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module rv_decoder #(
    parameter int NUM_REGS = 32
) (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::word_t     instr,
    input  logic              instr_req,
    input  logic              retire_busy,
    output logic              instr_ack,
    output logic              dec_valid,
    output rv_pkg::reg_num_t  rs1,
    output rv_pkg::reg_num_t  rs2,
    output rv_pkg::reg_num_t  rd,
    output rv_pkg::word_t     imm,
    output rv_pkg::alu_op_t   alu_op,
    output logic              use_imm,
    output logic              reg_we,
    output logic              illegal
);

    typedef enum logic {st_idle, st_ack_wait} state_t;

    state_t            state;
    logic              accept;
    rv_pkg::word_t     instr_q;

    rv_pkg::opcode_t   opcode;
    rv_pkg::funct3_t   funct3;
    logic [6:0]        funct7;
    rv_pkg::reg_num_t  rs1_f;
    rv_pkg::reg_num_t  rs2_f;
    rv_pkg::reg_num_t  rd_f;

    logic              legal;
    logic              alt;
    logic              use_rs1;
    logic              use_rs2;
    logic              regs_ok;
    rv_pkg::word_t     imm_d;
    rv_pkg::alu_op_t   op_d;

    function automatic rv_pkg::alu_op_t f3_op(rv_pkg::funct3_t f3, logic alt_sel);
        case (f3)
            rv_pkg::F3_ADD_SUB: f3_op = alt_sel ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            rv_pkg::F3_SLL:     f3_op = rv_pkg::ALU_SLL;
            rv_pkg::F3_SLT:     f3_op = rv_pkg::ALU_SLT;
            rv_pkg::F3_SLTU:    f3_op = rv_pkg::ALU_SLTU;
            rv_pkg::F3_XOR:     f3_op = rv_pkg::ALU_XOR;
            rv_pkg::F3_SRL_SRA: f3_op = alt_sel ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            rv_pkg::F3_OR:      f3_op = rv_pkg::ALU_OR;
            default:            f3_op = rv_pkg::ALU_AND;
        endcase
    endfunction

    assign accept = (state == st_idle) && instr_req && !retire_busy;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= st_idle;
            instr_ack <= 1'b0;
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= 1'b0; // Single cycle pulse
            case (state)
                st_idle: begin
                    if (accept) begin
                        instr_ack <= 1'b1;
                        dec_valid <= 1'b1;
                        state     <= st_ack_wait;
                    end
                end
                default: begin
                    if (!instr_req) begin
                        instr_ack <= 1'b0;
                        state     <= st_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            instr_q <= instr;
        end
    end

    assign opcode = instr_q[6:0];
    assign rd_f   = instr_q[11:7];
    assign funct3 = instr_q[14:12];
    assign rs1_f  = instr_q[19:15];
    assign rs2_f  = instr_q[24:20];
    assign funct7 = instr_q[31:25];

    always_comb begin
        legal   = 1'b0;
        alt     = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        use_imm = 1'b0;
        imm_d   = '0;
        case (opcode)
            rv_pkg::OPC_OP_IMM: begin
                use_rs1 = 1'b1;
                use_imm = 1'b1;
                imm_d   = {{20{instr_q[31]}}, instr_q[31:20]};
                case (funct3)
                    rv_pkg::F3_SLL: begin
                        legal = (funct7 == rv_pkg::F7_BASE);
                        imm_d = {27'd0, instr_q[24:20]}; // Shamt only
                    end
                    rv_pkg::F3_SRL_SRA: begin
                        legal = (funct7 == rv_pkg::F7_BASE) || (funct7 == rv_pkg::F7_ALT);
                        alt   = (funct7 == rv_pkg::F7_ALT);
                        imm_d = {27'd0, instr_q[24:20]};
                    end
                    default: legal = 1'b1;
                endcase
            end
            rv_pkg::OPC_OP: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                alt     = (funct7 == rv_pkg::F7_ALT);
                if (funct7 == rv_pkg::F7_BASE) begin
                    legal = 1'b1;
                end else if (alt) begin
                    legal = (funct3 == rv_pkg::F3_ADD_SUB) || (funct3 == rv_pkg::F3_SRL_SRA);
                end
            end
            rv_pkg::OPC_LUI: begin
                legal   = 1'b1;
                use_imm = 1'b1;
                imm_d   = {instr_q[31:12], 12'd0};
            end
            default: legal = 1'b0;
        endcase
        op_d = (opcode == rv_pkg::OPC_LUI) ? rv_pkg::ALU_LUI : f3_op(funct3, alt);
    end

    // RV32E style limit on register numbers
    assign regs_ok = (int'(rd_f) < NUM_REGS) &&
                     (!use_rs1 || int'(rs1_f) < NUM_REGS) &&
                     (!use_rs2 || int'(rs2_f) < NUM_REGS);

    assign illegal = !(legal && regs_ok);
    assign rs1     = (!illegal && use_rs1) ? rs1_f : '0;
    assign rs2     = (!illegal && use_rs2) ? rs2_f : '0;
    assign rd      = illegal ? '0 : rd_f;
    assign imm     = imm_d;
    assign alu_op  = illegal ? rv_pkg::ALU_ADD : op_d;
    assign reg_we  = !illegal && (rd_f != '0); // x0 is never written

endmodule

`default_nettype wire

// File: hw/rv_alu.sv
`timescale 1ns/10ps
`default_nettype none

module rv_alu (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              dec_valid,
    input  rv_pkg::alu_op_t   alu_op,
    input  logic              use_imm,
    input  rv_pkg::word_t     imm,
    input  rv_pkg::word_t     rs1_data,
    input  rv_pkg::word_t     rs2_data,
    input  rv_pkg::reg_num_t  rd,
    input  logic              reg_we,
    input  logic              illegal,
    output logic              alu_valid,
    output rv_pkg::word_t     alu_result,
    output rv_pkg::reg_num_t  rd_out,
    output logic              reg_we_out,
    output logic              illegal_out
);

    rv_pkg::word_t  op1;
    rv_pkg::word_t  op2;
    logic [4:0]     shamt;
    rv_pkg::word_t  result;

    assign op1   = rs1_data;
    assign op2   = use_imm ? imm : rs2_data;
    assign shamt = op2[4:0];

    always_comb begin
        case (alu_op)
            rv_pkg::ALU_ADD:  result = op1 + op2;
            rv_pkg::ALU_SUB:  result = op1 - op2; // Wraps
            rv_pkg::ALU_SLL:  result = op1 << shamt;
            rv_pkg::ALU_SLT:  result = {31'd0, $signed(op1) < $signed(op2)};
            rv_pkg::ALU_SLTU: result = {31'd0, op1 < op2};
            rv_pkg::ALU_XOR:  result = op1 ^ op2;
            rv_pkg::ALU_SRL:  result = op1 >> shamt;
            rv_pkg::ALU_SRA:  result = rv_pkg::word_t'($signed(op1) >>> shamt);
            rv_pkg::ALU_OR:   result = op1 | op2;
            rv_pkg::ALU_AND:  result = op1 & op2;
            rv_pkg::ALU_LUI:  result = imm;
            default:          result = '0;
        endcase
        if (illegal) begin
            result = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            alu_valid <= 1'b0;
        end else begin
            alu_valid <= dec_valid;
        end
    end

    // Result and forwarded fields
    always_ff @(posedge clk) begin
        if (dec_valid) begin
            alu_result  <= result;
            rd_out      <= rd;
            reg_we_out  <= reg_we;
            illegal_out <= illegal;
        end
    end

endmodule

`default_nettype wire

// File: hw/rv_retire.sv
`timescale 1ns/10ps
`default_nettype none

module rv_retire #(
    parameter int NUM_REGS = 32
) (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::reg_num_t  rs1,
    input  rv_pkg::reg_num_t  rs2,
    input  logic              alu_valid,
    input  rv_pkg::word_t     alu_result,
    input  rv_pkg::reg_num_t  rd,
    input  logic              reg_we,
    input  logic              illegal,
    input  logic              result_ack,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data,
    output logic              retire_busy,
    output logic              result_req,
    output rv_pkg::reg_num_t  result_rd,
    output rv_pkg::word_t     result_data,
    output logic              result_illegal
);

    typedef enum logic [1:0] {st_idle, st_present, st_release} state_t;

    state_t         state;
    rv_pkg::word_t  regs [NUM_REGS];

    // x0 and out of range numbers read as zero
    assign rs1_data = (rs1 != '0 && int'(rs1) < NUM_REGS) ? regs[rs1] : '0;
    assign rs2_data = (rs2 != '0 && int'(rs2) < NUM_REGS) ? regs[rs2] : '0;

    // Covers the alu_valid cycle before the FSM leaves idle
    assign retire_busy = alu_valid || (state != st_idle);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (alu_valid && reg_we) begin
            regs[rd] <= alu_result;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= st_idle;
            result_req <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (alu_valid) begin
                        result_req <= 1'b1;
                        state      <= st_present;
                    end
                end
                st_present: begin
                    if (result_ack) begin
                        result_req <= 1'b0;
                        state      <= st_release;
                    end
                end
                st_release: begin
                    if (!result_ack) begin // Wait for ack to drop
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Held stable while result_req is high
    always_ff @(posedge clk) begin
        if (alu_valid) begin
            result_rd      <= rd;
            result_data    <= alu_result;
            result_illegal <= illegal;
        end
    end

endmodule

`default_nettype wire

// File: hw/rv_exec_core.sv
`timescale 1ns/10ps
`default_nettype none

module rv_exec_core #(
    parameter int NUM_REGS = 32
) (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::word_t     instr,
    input  logic              instr_req,
    input  logic              result_ack,
    output logic              instr_ack,
    output logic              result_req,
    output rv_pkg::reg_num_t  result_rd,
    output rv_pkg::word_t     result_data,
    output logic              result_illegal
);

    logic              dec_valid;
    rv_pkg::reg_num_t  rs1;
    rv_pkg::reg_num_t  rs2;
    rv_pkg::reg_num_t  rd;
    rv_pkg::word_t     imm;
    rv_pkg::alu_op_t   alu_op;
    logic              use_imm;
    logic              reg_we;
    logic              illegal;
    rv_pkg::word_t     rs1_data;
    rv_pkg::word_t     rs2_data;

    logic              alu_valid;
    rv_pkg::word_t     alu_result;
    rv_pkg::reg_num_t  alu_rd;
    logic              alu_reg_we;
    logic              alu_illegal;
    logic              retire_busy;

    rv_decoder #(
        .NUM_REGS (NUM_REGS)
    ) rv_decoder_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_req   (instr_req),
        .retire_busy (retire_busy),
        .instr_ack   (instr_ack),
        .dec_valid   (dec_valid),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .imm         (imm),
        .alu_op      (alu_op),
        .use_imm     (use_imm),
        .reg_we      (reg_we),
        .illegal     (illegal)
    );

    rv_alu rv_alu_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .dec_valid   (dec_valid),
        .alu_op      (alu_op),
        .use_imm     (use_imm),
        .imm         (imm),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .rd          (rd),
        .reg_we      (reg_we),
        .illegal     (illegal),
        .alu_valid   (alu_valid),
        .alu_result  (alu_result),
        .rd_out      (alu_rd),
        .reg_we_out  (alu_reg_we),
        .illegal_out (alu_illegal)
    );

    rv_retire #(
        .NUM_REGS (NUM_REGS)
    ) rv_retire_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .rs1            (rs1),
        .rs2            (rs2),
        .alu_valid      (alu_valid),
        .alu_result     (alu_result),
        .rd             (alu_rd),
        .reg_we         (alu_reg_we),
        .illegal        (alu_illegal),
        .result_ack     (result_ack),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data),
        .retire_busy    (retire_busy),
        .result_req     (result_req),
        .result_rd      (result_rd),
        .result_data    (result_data),
        .result_illegal (result_illegal)
    );

endmodule

`default_nettype wire

// File: test/rv_tb_model.svh
function automatic rv_pkg::word_t enc_imm(rv_pkg::funct3_t f3, rv_pkg::reg_num_t rd,
                                          rv_pkg::reg_num_t rs1, logic [11:0] imm12);
    return {imm12, rs1, f3, rd, rv_pkg::OPC_OP_IMM};
endfunction

function automatic rv_pkg::word_t enc_shift(logic [6:0] f7, rv_pkg::funct3_t f3,
                                            rv_pkg::reg_num_t rd, rv_pkg::reg_num_t rs1,
                                            logic [4:0] shamt);
    return {f7, shamt, rs1, f3, rd, rv_pkg::OPC_OP_IMM};
endfunction

function automatic rv_pkg::word_t enc_reg(logic [6:0] f7, rv_pkg::funct3_t f3,
                                          rv_pkg::reg_num_t rd, rv_pkg::reg_num_t rs1,
                                          rv_pkg::reg_num_t rs2);
    return {f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
endfunction

function automatic rv_pkg::word_t enc_lui(rv_pkg::reg_num_t rd, logic [19:0] imm20);
    return {imm20, rd, rv_pkg::OPC_LUI};
endfunction

function automatic logic golden_illegal(rv_pkg::word_t w);
    logic [6:0] f7;
    f7 = w[31:25];
    case (w[6:0])
        rv_pkg::OPC_OP_IMM: begin
            if (w[14:12] == rv_pkg::F3_SLL) return f7 != rv_pkg::F7_BASE;
            if (w[14:12] == rv_pkg::F3_SRL_SRA)
                return f7 != rv_pkg::F7_BASE && f7 != rv_pkg::F7_ALT;
            return 1'b0;
        end
        rv_pkg::OPC_OP: begin
            if (f7 == rv_pkg::F7_BASE) return 1'b0;
            return !(f7 == rv_pkg::F7_ALT &&
                     (w[14:12] == rv_pkg::F3_ADD_SUB || w[14:12] == rv_pkg::F3_SRL_SRA));
        end
        rv_pkg::OPC_LUI: return 1'b0;
        default:         return 1'b1;
    endcase
endfunction

function automatic rv_pkg::word_t golden_value(rv_pkg::word_t w, rv_pkg::word_t a,
                                               rv_pkg::word_t b_reg);
    rv_pkg::word_t b;
    logic [4:0]    sh;
    logic          alt;
    if (golden_illegal(w)) return '0;
    if (w[6:0] == rv_pkg::OPC_LUI) return {w[31:12], 12'd0};
    b   = (w[6:0] == rv_pkg::OPC_OP_IMM) ? {{20{w[31]}}, w[31:20]} : b_reg;
    sh  = b[4:0]; // Equals the shamt field for shift immediates
    alt = (w[31:25] == rv_pkg::F7_ALT);
    case (w[14:12])
        rv_pkg::F3_ADD_SUB: return (w[6:0] == rv_pkg::OPC_OP && alt) ? a - b : a + b;
        rv_pkg::F3_SLL:     return a << sh;
        rv_pkg::F3_SLT:     return {31'd0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
        rv_pkg::F3_SLTU:    return {31'd0, a < b};
        rv_pkg::F3_XOR:     return a ^ b;
        rv_pkg::F3_SRL_SRA: return (alt && a[31]) ? (a >> sh) | ~(32'hffff_ffff >> sh) : a >> sh;
        rv_pkg::F3_OR:      return a | b;
        default:            return a & b;
    endcase
endfunction

// File: test/rv_exec_core_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module rv_exec_core_asserts (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::word_t     instr,
    input  logic              instr_req,
    input  logic              instr_ack,
    input  logic              result_req,
    input  logic              result_ack,
    input  rv_pkg::reg_num_t  result_rd,
    input  rv_pkg::word_t     result_data,
    input  logic              result_illegal
);

    `include "rv_tb_model.svh"

    int                fail_count;
    rv_pkg::word_t     shadow [32];
    rv_pkg::reg_num_t  exp_rd;
    rv_pkg::word_t     exp_data;
    logic              exp_illegal;
    int                outstanding;
    logic              ack_q;
    logic              req_q;
    logic              seen_req;

    initial fail_count = 0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                shadow[i] <= '0;
            end
            outstanding <= 0;
            ack_q       <= 1'b0;
            req_q       <= 1'b0;
            seen_req    <= 1'b0;
        end else begin
            ack_q <= instr_ack;
            req_q <= result_req;
            if (instr_req) begin
                seen_req <= 1'b1;
            end
            if (instr_ack && !ack_q) begin // Instruction accepted
                outstanding <= outstanding + 1;
                exp_illegal <= golden_illegal(instr);
                exp_rd      <= golden_illegal(instr) ? '0 : instr[11:7];
                exp_data    <= golden_value(instr, shadow[instr[19:15]], shadow[instr[24:20]]);
            end else if (result_req && !req_q) begin
                outstanding <= outstanding - 1;
            end
            if (result_req && result_ack && exp_rd != '0) begin
                shadow[exp_rd] <= exp_data;
            end
        end
    end

    a_idle_until_req: assert property (@(posedge clk) disable iff (!rst_n)
        !seen_req |-> !instr_ack && !result_req)
        else begin
            $error("Error at %0t: handshake active before the first request", $time);
            fail_count++;
        end

    a_one_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(instr_ack) |-> outstanding == 0 && !result_req && !result_ack)
        else begin
            $error("Error at %0t: instr_ack given before the previous result closed", $time);
            fail_count++;
        end

    a_one_result: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(result_req) |-> outstanding == 1)
        else begin
            $error("Error at %0t: result_req without a matching instr_ack", $time);
            fail_count++;
        end

    a_result_value: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(result_req) |->
            result_rd == exp_rd && result_data == exp_data && result_illegal == exp_illegal)
        else begin
            $error("Error at %0t: result rd %0d data %h illegal %0b, expected %0d %h %0b",
                   $time, result_rd, result_data, result_illegal,
                   exp_rd, exp_data, exp_illegal);
            fail_count++;
        end

    a_result_hold: assert property (@(posedge clk) disable iff (!rst_n)
        result_req && !result_ack |=> result_req && $stable(result_rd) &&
            $stable(result_data) && $stable(result_illegal))
        else begin
            $error("Error at %0t: result fields changed under back-pressure", $time);
            fail_count++;
        end

endmodule

bind rv_exec_core rv_exec_core_asserts rv_exec_core_asserts_i (.*);

`default_nettype wire

// File: test/rv_exec_core_tb.sv
`timescale 1ns/10ps
`default_nettype none

module rv_exec_core_tb;

    `include "rv_tb_model.svh"

    localparam int TIMEOUT = 200; // Cycles per wait

    logic              clk;
    logic              rst_n;
    rv_pkg::word_t     instr;
    logic              instr_req;
    logic              result_ack;
    logic              instr_ack;
    logic              result_req;
    rv_pkg::reg_num_t  result_rd;
    rv_pkg::word_t     result_data;
    logic              result_illegal;

    int timeouts;
    int tests_ok;
    int tests_bad;
    int fails_mark;
    int timeouts_mark;

    rv_exec_core #(
        .NUM_REGS (32)
    ) rv_exec_core_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr          (instr),
        .instr_req      (instr_req),
        .result_ack     (result_ack),
        .instr_ack      (instr_ack),
        .result_req     (result_req),
        .result_rd      (result_rd),
        .result_data    (result_data),
        .result_illegal (result_illegal)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic wait_instr_ack(input logic level);
        int n;
        n = 0;
        while (instr_ack !== level && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (instr_ack !== level) begin
            $display("Timeout at %0t: instr_ack never went to %0b", $time, level);
            timeouts++;
        end
    endtask

    task automatic wait_result_req(input logic level);
        int n;
        n = 0;
        while (result_req !== level && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (result_req !== level) begin
            $display("Timeout at %0t: result_req never went to %0b", $time, level);
            timeouts++;
        end
    endtask

    task automatic send_instr(input rv_pkg::word_t w);
        wait_instr_ack(1'b0);
        instr     = w;
        instr_req = 1'b1;
        wait_instr_ack(1'b1);
        instr_req = 1'b0;
    endtask

    task automatic take_result(input int delay);
        wait_result_req(1'b1);
        repeat (delay) @(negedge clk); // Back-pressure
        result_ack = 1'b1;
        wait_result_req(1'b0);
        result_ack = 1'b0;
    endtask

    task automatic exec(input rv_pkg::word_t w);
        send_instr(w);
        take_result(int'($urandom_range(5, 0)));
    endtask

    task automatic run_imm_ops(input rv_pkg::reg_num_t rs1);
        for (int k = 0; k < 8; k++) begin
            if (k == 1 || k == 5) begin
                exec(enc_shift(rv_pkg::F7_BASE, 3'(k), 5'(5 + k), rs1, 5'($urandom)));
            end else begin
                exec(enc_imm(3'(k), 5'(5 + k), rs1, 12'($urandom)));
            end
        end
        exec(enc_shift(rv_pkg::F7_ALT, rv_pkg::F3_SRL_SRA, 5'd13, rs1, 5'($urandom)));
    endtask

    task automatic run_reg_ops(input rv_pkg::reg_num_t a, input rv_pkg::reg_num_t b);
        for (int k = 0; k < 8; k++) begin
            exec(enc_reg(rv_pkg::F7_BASE, 3'(k), 5'(16 + k), a, b));
        end
        exec(enc_reg(rv_pkg::F7_ALT, rv_pkg::F3_ADD_SUB, 5'd24, a, b));
        exec(enc_reg(rv_pkg::F7_ALT, rv_pkg::F3_SRL_SRA, 5'd25, a, b));
    endtask

    task automatic end_test(input string name);
        int fails;
        int bad;
        fails = rv_exec_core_i.rv_exec_core_asserts_i.fail_count;
        bad   = (fails - fails_mark) + (timeouts - timeouts_mark);
        if (bad == 0) begin
            tests_ok++;
        end else begin
            tests_bad++;
        end
        $display("Test %s: %s", name, (bad == 0) ? "ok" : "failed");
        fails_mark    = fails;
        timeouts_mark = timeouts;
    endtask

    initial begin
        void'($urandom(36));
        rst_n = 1'b0;
        instr = '0;
        instr_req = 1'b0;
        result_ack = 1'b0;
        timeouts = 0;
        tests_ok = 0;
        tests_bad = 0;
        fails_mark = 0;
        timeouts_mark = 0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        repeat (4) @(negedge clk); // Idle before the first request
        exec(enc_imm(rv_pkg::F3_ADD_SUB, 5'd1, 5'd0, 12'h123));
        end_test("reset_idle");

        // x1 and x3 positive, x2 and x4 negative
        for (int r = 1; r <= 4; r++) begin
            exec(enc_lui(5'(r), {r[0] == 1'b0, 19'($urandom)}));
            exec(enc_imm(rv_pkg::F3_ADD_SUB, 5'(r), 5'(r), 12'($urandom)));
        end
        run_imm_ops(5'd3);
        run_imm_ops(5'd4);
        end_test("op_imm");

        run_reg_ops(5'd1, 5'd2);
        run_reg_ops(5'd2, 5'd1);
        run_reg_ops(5'd4, 5'd2);
        end_test("op_reg");

        exec(enc_imm(rv_pkg::F3_ADD_SUB, 5'd0, 5'd1, 12'h5a5));
        exec(enc_reg(rv_pkg::F7_BASE, rv_pkg::F3_ADD_SUB, 5'd6, 5'd0, 5'd0));
        exec(enc_reg(rv_pkg::F7_BASE, rv_pkg::F3_OR, 5'd7, 5'd1, 5'd0));
        end_test("x0_write");

        exec(32'h0000_2083); // LW x1, 0(x0)
        exec(enc_reg(7'b0000001, rv_pkg::F3_ADD_SUB, 5'd3, 5'd1, 5'd2));
        exec(enc_shift(rv_pkg::F7_ALT, rv_pkg::F3_SLL, 5'd4, 5'd1, 5'd3));
        exec(enc_reg(rv_pkg::F7_BASE, rv_pkg::F3_ADD_SUB, 5'd8, 5'd1, 5'd0));
        exec(enc_reg(rv_pkg::F7_BASE, rv_pkg::F3_ADD_SUB, 5'd9, 5'd3, 5'd0));
        exec(enc_reg(rv_pkg::F7_BASE, rv_pkg::F3_ADD_SUB, 5'd10, 5'd4, 5'd0));
        end_test("illegal");

        for (int d = 2; d <= 6; d += 4) begin
            send_instr(enc_reg(rv_pkg::F7_BASE, rv_pkg::F3_XOR, 5'd11, 5'd1, 5'd2));
            fork
                take_result(d);
                send_instr(enc_imm(rv_pkg::F3_ADD_SUB, 5'd12, 5'd11, 12'($urandom)));
            join
            take_result(1);
        end
        end_test("back_pressure");

        $display("Tests passed %0d, failed %0d, assertion failures %0d, timeouts %0d",
                 tests_ok, tests_bad, fails_mark, timeouts);
        if (tests_bad == 0 && fails_mark == 0 && timeouts == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+test
hw/rv_pkg.sv
hw/rv_decoder.sv
hw/rv_alu.sv
hw/rv_retire.sv
hw/rv_exec_core.sv
test/rv_exec_core_asserts.sv
test/rv_exec_core_tb.sv
